// File: Makefile
SIM_LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module ctrl_top \
		design/ctrl_pkg.sv design/ctrl_exc_prio.sv design/ctrl_irq_arb.sv \
		design/ctrl_fsm.sv design/ctrl_top.sv

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_ctrl -f verilog.f
	./obj_dir/Vtb_ctrl | tee $(SIM_LOG)
	@if grep -q "TEST RESULT: FAIL" $(SIM_LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: bench/tb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl;

	localparam int unsigned NumFastIrqs = 15;
	localparam int          NumTests    = 6;
	localparam int          WatchdogNs  = (NumTests * 40 + 20) * 100;

	logic                   clk_i;
	logic                   rst_ni;
	logic                   instr_valid_i;
	ctrl_pkg::id_flags_t    flags_i;
	ctrl_pkg::word_t        instr_i;
	ctrl_pkg::half_t        instr_c_i;
	logic                   is_compressed_i;
	ctrl_pkg::word_t        pc_id_i;
	ctrl_pkg::priv_lvl_e    priv_i;
	logic                   branch_set_i;
	logic                   jump_set_i;
	logic                   stall_i;
	logic                   ready_wb_i;
	logic                   instr_exec_i;
	logic                   load_err_i;
	logic                   store_err_i;
	ctrl_pkg::word_t        lsu_addr_i;
	logic [NumFastIrqs-1:0] irq_fast_i;
	logic                   irq_external_i;
	logic                   irq_software_i;
	logic                   irq_timer_i;
	logic                   irq_nm_i;
	logic                   mie_i;
	logic                   special_pc_o;
	logic                   ctrl_busy_o;
	logic                   instr_req_o;
	logic                   pc_set_o;
	ctrl_pkg::pc_sel_e      pc_sel_o;
	ctrl_pkg::exc_pc_sel_e  exc_pc_sel_o;
	ctrl_pkg::exc_cause_t   exc_cause_o;
	ctrl_pkg::csr_ctrl_t    csr_o;
	logic                   nmi_mode_o;
	logic                   id_in_ready_o;
	logic                   instr_valid_clear_o;
	logic                   flush_id_o;
	integer                 seed;
	int                     errors;
	int                     checks;
	ctrl_pkg::word_t        stim_instr;
	ctrl_pkg::word_t        stim_pc;
	ctrl_pkg::word_t        stim_addr;

	ctrl_top #(
		.NumFastIrqs (NumFastIrqs)
	) i_dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	initial begin
		#(WatchdogNs);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		$display("test %s finished with %0d errors", name, errors - start);
	endtask

	// NMI wins over the lowest fast line, which wins over the rest
	function automatic ctrl_pkg::exc_cause_t irq_cause_for(input logic [NumFastIrqs-1:0] fast,
			input logic ext, input logic sw, input logic tmr, input logic nm);
		ctrl_pkg::exc_cause_t cause;
		logic                 found;
		cause = 7'd0;
		found = 1'b0;
		for (int i = 0; i < NumFastIrqs; i++) begin
			if (fast[i] && !found) begin
				cause = 7'(48 + i);
				found = 1'b1;
			end
		end
		if (nm) begin
			cause = 7'd63;
		end else if (!found) begin
			if (ext) begin
				cause = 7'd43;
			end else if (sw) begin
				cause = 7'd35;
			end else if (tmr) begin
				cause = 7'd39;
			end
		end
		return cause;
	endfunction

	task automatic wait_state(input ctrl_pkg::ctrl_state_e target, input int max_cycles);
		int n;
		n = 0;
		while (i_dut.state != target && n < max_cycles) begin
			@(negedge clk_i);
			#10;
			n++;
		end
		if (i_dut.state != target) begin
			$display("controller did not reach %s within %0d cycles", target.name(), max_cycles);
			errors++;
		end
	endtask

	task automatic clear_instr();
		instr_valid_i   = 1'b0;
		flags_i         = '0;
		is_compressed_i = 1'b0;
		load_err_i      = 1'b0;
		store_err_i     = 1'b0;
	endtask

	task automatic drop_irqs();
		irq_fast_i     = '0;
		irq_external_i = 1'b0;
		irq_software_i = 1'b0;
		irq_timer_i    = 1'b0;
		irq_nm_i       = 1'b0;
	endtask

	// one excepting request with FLUSH exactly one cycle later
	task automatic run_exc(input string name, input ctrl_pkg::id_flags_t f, input logic comp,
			input logic ld, input logic st, input ctrl_pkg::exc_cause_t exp_cause,
			input ctrl_pkg::word_t exp_mtval);
		@(negedge clk_i);
		instr_valid_i   = (f != '0);
		flags_i         = f;
		instr_i         = stim_instr;
		instr_c_i       = stim_instr[31:16];
		is_compressed_i = comp;
		pc_id_i         = stim_pc;
		lsu_addr_i      = stim_addr;
		load_err_i      = ld;
		store_err_i     = st;
		#10;
		check_eq({name, " pc_set_o"}, pc_set_o, 1'b0);
		check_eq({name, " id_in_ready_o"}, id_in_ready_o, 1'b0);
		check_eq({name, " special_pc_o"}, special_pc_o, 1'b1);
		@(negedge clk_i);
		clear_instr();
		#10;
		check_eq({name, " pc_set_o"}, pc_set_o, 1'b1);
		check_eq({name, " pc_sel_o"}, pc_sel_o, ctrl_pkg::PC_EXC);
		check_eq({name, " exc_pc_sel_o"}, exc_pc_sel_o, ctrl_pkg::EXC_PC_EXC);
		check_eq({name, " exc_cause_o"}, exc_cause_o, exp_cause);
		check_eq({name, " csr_o.mtval"}, csr_o.mtval, exp_mtval);
		check_eq({name, " csr_o.save_cause"}, csr_o.save_cause, 1'b1);
		check_eq({name, " csr_o.save_id"}, csr_o.save_id, 1'b1);
		check_eq({name, " flush_id_o"}, flush_id_o, 1'b1);
		check_eq({name, " instr_valid_clear_o"}, instr_valid_clear_o, 1'b1);
		@(negedge clk_i);
		#10;
		check_eq({name, " state"}, i_dut.state, ctrl_pkg::DECODE);
		check_eq({name, " pc_set_o"}, pc_set_o, 1'b0);
		check_eq({name, " flush_id_o"}, flush_id_o, 1'b0);
	endtask

	// expect IRQ_TAKEN for the lines already driven and then drop them
	task automatic take_irq();
		ctrl_pkg::exc_cause_t exp;
		int                   n;
		exp = irq_cause_for(irq_fast_i, irq_external_i, irq_software_i, irq_timer_i, irq_nm_i);
		n   = 0;
		#10;
		while (!(pc_set_o === 1'b1 && exc_pc_sel_o === ctrl_pkg::EXC_PC_IRQ) && n < 10) begin
			@(negedge clk_i);
			#10;
			n++;
		end
		if (!(pc_set_o === 1'b1 && exc_pc_sel_o === ctrl_pkg::EXC_PC_IRQ)) begin
			$display("interrupt with cause %0d was not taken within 10 cycles", exp);
			errors++;
		end else begin
			check_eq("exc_cause_o", exc_cause_o, exp);
			check_eq("pc_sel_o", pc_sel_o, ctrl_pkg::PC_EXC);
			check_eq("csr_o.save_if", csr_o.save_if, 1'b1);
			check_eq("csr_o.save_cause", csr_o.save_cause, 1'b1);
		end
		@(negedge clk_i);
		drop_irqs();
	endtask

	task automatic watch_no_irq(input int cycles);
		int seen;
		seen = 0;
		for (int n = 0; n < cycles; n++) begin
			@(negedge clk_i);
			#10;
			if (pc_set_o === 1'b1 && exc_pc_sel_o === ctrl_pkg::EXC_PC_IRQ) begin
				seen++;
			end
		end
		if (seen != 0) begin
			$display("an interrupt that should wait was taken %0d times", seen);
			errors++;
		end
	endtask

	task automatic boot_and_branch();
		int start;
		start  = errors;
		rst_ni = 1'b0;
		@(posedge clk_i);
		@(negedge clk_i);
		#10;
		check_eq("pc_set_o", pc_set_o, 1'b1);
		check_eq("pc_sel_o", pc_sel_o, ctrl_pkg::PC_BOOT);
		check_eq("instr_req_o", instr_req_o, 1'b0);
		check_eq("ctrl_busy_o", ctrl_busy_o, 1'b1);
		check_eq("nmi_mode_o", nmi_mode_o, 1'b0);
		check_eq("csr_o", csr_o, '0);
		@(negedge clk_i);
		rst_ni = 1'b1;
		wait_state(ctrl_pkg::DECODE, 10);
		check_eq("id_in_ready_o", id_in_ready_o, 1'b1);
		check_eq("instr_req_o", instr_req_o, 1'b1);
		// branch and jump redirect in the same cycle
		@(negedge clk_i);
		branch_set_i = 1'b1;
		#10;
		check_eq("pc_set_o", pc_set_o, 1'b1);
		check_eq("pc_sel_o", pc_sel_o, ctrl_pkg::PC_JUMP);
		@(negedge clk_i);
		branch_set_i = 1'b0;
		jump_set_i   = 1'b1;
		#10;
		check_eq("pc_set_o", pc_set_o, 1'b1);
		check_eq("pc_sel_o", pc_sel_o, ctrl_pkg::PC_JUMP);
		@(negedge clk_i);
		jump_set_i = 1'b0;
		report_test("boot", start);
	endtask

	task automatic illegal_priority();
		ctrl_pkg::id_flags_t f;
		int                  start;
		start      = errors;
		stim_instr = $random(seed);
		stim_pc    = $random(seed);
		f          = '0;
		f.illegal  = 1'b1;
		run_exc("illegal", f, 1'b0, 1'b0, 1'b0, 7'd2, stim_instr);
		run_exc("illegal compressed", f, 1'b1, 1'b0, 1'b0, 7'd2, {16'h0000, stim_instr[31:16]});
		f.fetch_err = 1'b1;
		run_exc("fetch fault", f, 1'b0, 1'b0, 1'b0, 7'd1, stim_pc);
		f.fetch_err_plus2 = 1'b1;
		run_exc("fetch fault plus2", f, 1'b0, 1'b0, 1'b0, 7'd1, stim_pc + 32'd2);
		report_test("illegal", start);
	endtask

	task automatic ecall_lsu_faults();
		ctrl_pkg::id_flags_t f;
		int                  start;
		start   = errors;
		f       = '0;
		f.ecall = 1'b1;
		run_exc("ecall m", f, 1'b0, 1'b0, 1'b0, 7'd11, 32'h0);
		@(negedge clk_i);
		priv_i = ctrl_pkg::PRIV_U;
		run_exc("ecall u", f, 1'b0, 1'b0, 1'b0, 7'd8, 32'h0);
		@(negedge clk_i);
		priv_i    = ctrl_pkg::PRIV_M;
		stim_addr = $random(seed);
		run_exc("load fault", '0, 1'b0, 1'b1, 1'b0, 7'd5, stim_addr);
		stim_addr = $random(seed);
		run_exc("store fault", '0, 1'b0, 1'b0, 1'b1, 7'd7, stim_addr);
		f      = '0;
		f.ebrk = 1'b1;
		run_exc("ebreak", f, 1'b0, 1'b0, 1'b0, 7'd3, 32'h0);
		report_test("ecall_lsu", start);
	endtask

	task automatic irq_select();
		int start;
		start = errors;
		@(negedge clk_i);
		mie_i          = 1'b1;
		irq_fast_i[3]  = 1'b1;
		irq_fast_i[7]  = 1'b1;
		irq_external_i = 1'b1;
		take_irq();
		@(negedge clk_i);
		irq_external_i = 1'b1;
		take_irq();
		@(negedge clk_i);
		irq_software_i = 1'b1;
		take_irq();
		@(negedge clk_i);
		irq_timer_i = 1'b1;
		take_irq();
		// disabled in M mode
		@(negedge clk_i);
		mie_i          = 1'b0;
		irq_external_i = 1'b1;
		watch_no_irq(10);
		@(negedge clk_i);
		drop_irqs();
		report_test("irq_select", start);
	endtask

	task automatic nmi_nesting();
		ctrl_pkg::id_flags_t f;
		int                  start;
		start = errors;
		@(negedge clk_i);
		irq_nm_i = 1'b1;
		take_irq();
		#10;
		check_eq("nmi_mode_o", nmi_mode_o, 1'b1);
		@(negedge clk_i);
		irq_nm_i = 1'b1;
		watch_no_irq(5);
		@(negedge clk_i);
		irq_nm_i = 1'b0;
		f        = '0;
		f.mret   = 1'b1;
		@(negedge clk_i);
		instr_valid_i = 1'b1;
		flags_i       = f;
		#10;
		check_eq("special_pc_o", special_pc_o, 1'b1);
		wait_state(ctrl_pkg::FLUSH, 5);
		check_eq("pc_set_o", pc_set_o, 1'b1);
		check_eq("pc_sel_o", pc_sel_o, ctrl_pkg::PC_MRET);
		check_eq("csr_o.restore_mret", csr_o.restore_mret, 1'b1);
		@(negedge clk_i);
		clear_instr();
		#10;
		check_eq("nmi_mode_o", nmi_mode_o, 1'b0);
		report_test("nmi", start);
	endtask

	task automatic wfi_backpressure();
		ctrl_pkg::id_flags_t f;
		int                  start;
		start = errors;
		f     = '0;
		f.wfi = 1'b1;
		@(negedge clk_i);
		instr_valid_i = 1'b1;
		flags_i       = f;
		#10;
		check_eq("special_pc_o", special_pc_o, 1'b0);
		wait_state(ctrl_pkg::WAIT_SLEEP, 5);
		check_eq("ctrl_busy_o", ctrl_busy_o, 1'b0);
		check_eq("instr_req_o", instr_req_o, 1'b0);
		check_eq("flush_id_o", flush_id_o, 1'b1);
		@(negedge clk_i);
		clear_instr();
		#10;
		check_eq("ctrl_busy_o", ctrl_busy_o, 1'b0);
		check_eq("instr_req_o", instr_req_o, 1'b0);
		// wake on a fast line
		@(negedge clk_i);
		mie_i         = 1'b1;
		irq_fast_i[0] = 1'b1;
		wait_state(ctrl_pkg::FIRST_FETCH, 5);
		check_eq("instr_req_o", instr_req_o, 1'b1);
		take_irq();
		@(negedge clk_i);
		stall_i = 1'b1;
		#10;
		check_eq("id_in_ready_o", id_in_ready_o, 1'b0);
		@(negedge clk_i);
		irq_external_i = 1'b1;
		watch_no_irq(3);
		check_eq("id_in_ready_o", id_in_ready_o, 1'b0);
		@(negedge clk_i);
		stall_i = 1'b0;
		take_irq();
		// illegal instruction held back by the later stage
		stim_instr = $random(seed);
		f          = '0;
		f.illegal  = 1'b1;
		@(negedge clk_i);
		ready_wb_i    = 1'b0;
		instr_valid_i = 1'b1;
		flags_i       = f;
		instr_i       = stim_instr;
		for (int n = 0; n < 3; n++) begin
			#10;
			check_eq("pc_set_o", pc_set_o, 1'b0);
			check_eq("id_in_ready_o", id_in_ready_o, 1'b0);
			check_eq("instr_valid_clear_o", instr_valid_clear_o, 1'b0);
			@(negedge clk_i);
		end
		ready_wb_i = 1'b1;
		wait_state(ctrl_pkg::FLUSH, 5);
		check_eq("pc_set_o", pc_set_o, 1'b1);
		check_eq("exc_cause_o", exc_cause_o, 7'd2);
		check_eq("csr_o.mtval", csr_o.mtval, stim_instr);
		@(negedge clk_i);
		clear_instr();
		report_test("wfi_stall", start);
	endtask

	initial begin
		seed            = 32'hec11_8168;
		errors          = 0;
		checks          = 0;
		stim_instr      = '0;
		stim_pc         = '0;
		stim_addr       = '0;
		rst_ni          = 1'b0;
		instr_i         = '0;
		instr_c_i       = '0;
		pc_id_i         = '0;
		lsu_addr_i      = '0;
		priv_i          = ctrl_pkg::PRIV_M;
		branch_set_i    = 1'b0;
		jump_set_i      = 1'b0;
		stall_i         = 1'b0;
		ready_wb_i      = 1'b1;
		instr_exec_i    = 1'b1;
		mie_i           = 1'b0;
		clear_instr();
		drop_irqs();
		boot_and_branch();
		illegal_priority();
		ecall_lsu_faults();
		irq_select();
		nmi_nesting();
		wfi_backpressure();
		$display("%0d tests, %0d checks, %0d errors", NumTests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/ctrl_exc_prio.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_exc_prio (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  instr_valid_i,
	input  ctrl_pkg::id_flags_t   flags_i,
	input  ctrl_pkg::word_t       instr_i,
	input  ctrl_pkg::half_t       instr_c_i,
	input  logic                  is_compressed_i,
	input  ctrl_pkg::word_t       pc_id_i,
	input  ctrl_pkg::priv_lvl_e   priv_i,
	input  logic                  load_err_i,
	input  logic                  store_err_i,
	input  ctrl_pkg::word_t       lsu_addr_i,
	input  ctrl_pkg::ctrl_state_e state_i,
	output ctrl_pkg::exc_req_t    exc_o,
	output logic                  special_o,
	output logic                  special_pc_o
);

	ctrl_pkg::id_flags_t  flags;
	logic                 in_flush;
	logic                 fetch_prio;
	logic                 illegal_prio;
	logic                 ecall_prio;
	logic                 ebrk_prio;
	logic                 store_prio;
	logic                 load_prio;
	logic                 exc_req;
	ctrl_pkg::exc_req_t   exc_d;
	logic                 valid_q;
	logic                 is_lsu_q;
	ctrl_pkg::exc_cause_t cause_q;
	ctrl_pkg::word_t      mtval_q;

	// decoder flags only count for a valid instruction
	assign flags = instr_valid_i ? flags_i : '0;

	// no new requests while the pipe is being flushed
	assign in_flush = (state_i == ctrl_pkg::FLUSH);

	// fixed priority, first match wins
	always_comb begin
		fetch_prio   = 1'b0;
		illegal_prio = 1'b0;
		ecall_prio   = 1'b0;
		ebrk_prio    = 1'b0;
		store_prio   = 1'b0;
		load_prio    = 1'b0;
		if (!in_flush) begin
			if (flags.fetch_err) begin
				fetch_prio = 1'b1;
			end else if (flags.illegal) begin
				illegal_prio = 1'b1;
			end else if (flags.ecall) begin
				ecall_prio = 1'b1;
			end else if (flags.ebrk) begin
				ebrk_prio = 1'b1;
			end else if (store_err_i) begin
				store_prio = 1'b1;
			end else if (load_err_i) begin
				load_prio = 1'b1;
			end
		end
	end

	assign exc_req = fetch_prio | illegal_prio | ecall_prio | ebrk_prio | store_prio | load_prio;

	// cause and trap value of the winner
	always_comb begin
		exc_d        = '0;
		exc_d.valid  = exc_req;
		exc_d.is_lsu = store_prio | load_prio;
		if (fetch_prio) begin
			exc_d.cause = ctrl_pkg::CauseInstrFault;
			exc_d.mtval = flags.fetch_err_plus2 ? pc_id_i + 32'd2 : pc_id_i;
		end else if (illegal_prio) begin
			exc_d.cause = ctrl_pkg::CauseIllegal;
			exc_d.mtval = is_compressed_i ? {16'h0000, instr_c_i} : instr_i;
		end else if (ecall_prio) begin
			exc_d.cause = (priv_i == ctrl_pkg::PRIV_M) ? ctrl_pkg::CauseEcallM :
				ctrl_pkg::CauseEcallU;
		end else if (ebrk_prio) begin
			exc_d.cause = ctrl_pkg::CauseBreakpoint;
		end else if (store_prio) begin
			exc_d.cause = ctrl_pkg::CauseStoreFault;
			exc_d.mtval = lsu_addr_i;
		end else if (load_prio) begin
			exc_d.cause = ctrl_pkg::CauseLoadFault;
			exc_d.mtval = lsu_addr_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q  <= 1'b0;
			is_lsu_q <= 1'b0;
			cause_q  <= '0;
		end else begin
			valid_q  <= exc_d.valid;
			is_lsu_q <= exc_d.is_lsu;
			cause_q  <= exc_d.cause;
		end
	end

	always_ff @(posedge clk_i) begin
		mtval_q <= exc_d.mtval;
	end

	always_comb begin
		exc_o        = '0;
		exc_o.valid  = valid_q;
		exc_o.is_lsu = is_lsu_q;
		exc_o.cause  = cause_q;
		exc_o.mtval  = mtval_q;
	end

	// redirecting requests vs. flush-only ones
	assign special_pc_o = exc_req | flags.mret;
	assign special_o    = special_pc_o | flags.wfi | flags.csr_pipe_flush;

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		$onehot0({fetch_prio, illegal_prio, ecall_prio, ebrk_prio, store_prio, load_prio}))
		else $error("more than one exception granted");

endmodule

`default_nettype wire

// File: design/ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   instr_valid_i,
	input  ctrl_pkg::id_flags_t    flags_i,
	input  ctrl_pkg::exc_req_t     exc_i,
	input  logic                   special_i,
	input  logic                   handle_irq_i,
	input  logic                   nmi_i,
	input  ctrl_pkg::exc_cause_t   irq_cause_i,
	input  logic                   irq_pending_i,
	input  logic                   branch_set_i,
	input  logic                   jump_set_i,
	input  logic                   stall_i,
	input  logic                   ready_wb_i,
	input  logic                   instr_exec_i,
	output ctrl_pkg::ctrl_state_e  state_o,
	output logic                   ctrl_busy_o,
	output logic                   instr_req_o,
	output logic                   pc_set_o,
	output ctrl_pkg::pc_sel_e      pc_sel_o,
	output ctrl_pkg::exc_pc_sel_e  exc_pc_sel_o,
	output ctrl_pkg::exc_cause_t   exc_cause_o,
	output ctrl_pkg::csr_ctrl_t    csr_o,
	output logic                   nmi_mode_o,
	output logic                   id_in_ready_o,
	output logic                   instr_valid_clear_o,
	output logic                   flush_id_o
);

	ctrl_pkg::ctrl_state_e state_q;
	ctrl_pkg::ctrl_state_e state_d;
	logic                  nmi_mode_q;
	logic                  nmi_mode_d;
	logic                  halt_if;
	logic                  retain_id;
	logic                  flush_id;
	logic                  id_wb_pending;
	logic                  mret_insn;
	logic                  wfi_insn;

	assign mret_insn     = flags_i.mret & instr_valid_i;
	assign wfi_insn      = flags_i.wfi & instr_valid_i;
	assign id_wb_pending = instr_valid_i | ~ready_wb_i;

	always_comb begin
		state_d      = state_q;
		nmi_mode_d   = nmi_mode_q;
		ctrl_busy_o  = 1'b1;
		instr_req_o  = 1'b1;
		pc_set_o     = 1'b0;
		pc_sel_o     = ctrl_pkg::PC_BOOT;
		exc_pc_sel_o = ctrl_pkg::EXC_PC_EXC;
		exc_cause_o  = '0;
		csr_o        = '0;
		halt_if      = 1'b0;
		retain_id    = 1'b0;
		flush_id     = 1'b0;

		unique case (state_q)
			ctrl_pkg::RESET: begin
				instr_req_o = 1'b0;
				pc_set_o    = 1'b1;
				state_d     = ctrl_pkg::BOOT_SET;
			end
			ctrl_pkg::BOOT_SET: begin
				pc_set_o = 1'b1;
				state_d  = ctrl_pkg::FIRST_FETCH;
			end
			ctrl_pkg::FIRST_FETCH: begin
				if (handle_irq_i) begin
					halt_if = 1'b1;
					state_d = ctrl_pkg::IRQ_TAKEN;
				end else if (!stall_i && instr_exec_i) begin
					state_d = ctrl_pkg::DECODE;
				end
			end
			ctrl_pkg::DECODE: begin
				pc_sel_o = ctrl_pkg::PC_JUMP;
				// hold the instruction until the later stage drains
				if (special_i) begin
					retain_id = 1'b1;
					if (ready_wb_i) begin
						state_d = ctrl_pkg::FLUSH;
					end
				end
				if (branch_set_i || jump_set_i) begin
					pc_set_o = 1'b1;
				end
				if (handle_irq_i && (stall_i || id_wb_pending)) begin
					halt_if = 1'b1;
				end
				if (handle_irq_i && !stall_i && !special_i && !id_wb_pending) begin
					halt_if = 1'b1;
					state_d = ctrl_pkg::IRQ_TAKEN;
				end
			end
			ctrl_pkg::IRQ_TAKEN: begin
				pc_sel_o     = ctrl_pkg::PC_EXC;
				exc_pc_sel_o = ctrl_pkg::EXC_PC_IRQ;
				if (handle_irq_i) begin
					pc_set_o         = 1'b1;
					csr_o.save_if    = 1'b1;
					csr_o.save_cause = 1'b1;
					exc_cause_o      = irq_cause_i;
					if (nmi_i) begin
						nmi_mode_d = 1'b1;
					end
				end
				state_d = ctrl_pkg::DECODE;
			end
			ctrl_pkg::FLUSH: begin
				halt_if  = 1'b1;
				flush_id = 1'b1;
				state_d  = ctrl_pkg::DECODE;
				if (exc_i.valid) begin
					pc_set_o         = 1'b1;
					pc_sel_o         = ctrl_pkg::PC_EXC;
					csr_o.save_id    = 1'b1;
					csr_o.save_cause = 1'b1;
					csr_o.mtval      = exc_i.mtval;
					exc_cause_o      = exc_i.cause;
				end else if (mret_insn) begin
					pc_set_o           = 1'b1;
					pc_sel_o           = ctrl_pkg::PC_MRET;
					csr_o.restore_mret = 1'b1;
					nmi_mode_d         = 1'b0;
				end else if (wfi_insn) begin
					state_d = ctrl_pkg::WAIT_SLEEP;
				end
			end
			ctrl_pkg::WAIT_SLEEP: begin
				ctrl_busy_o = 1'b0;
				instr_req_o = 1'b0;
				halt_if     = 1'b1;
				flush_id    = 1'b1;
				state_d     = ctrl_pkg::SLEEP;
			end
			ctrl_pkg::SLEEP: begin
				instr_req_o = 1'b0;
				halt_if     = 1'b1;
				flush_id    = 1'b1;
				if (irq_pending_i) begin
					state_d = ctrl_pkg::FIRST_FETCH;
				end else begin
					ctrl_busy_o = 1'b0;
				end
			end
			default: begin
				instr_req_o = 1'b0;
				state_d     = ctrl_pkg::RESET;
			end
		endcase

		// fetch is paused while the execute stage is busy
		if (!instr_exec_i) begin
			halt_if = 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q    <= ctrl_pkg::RESET;
			nmi_mode_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			nmi_mode_q <= nmi_mode_d;
		end
	end

	assign state_o             = state_q;
	assign nmi_mode_o          = nmi_mode_q;
	assign flush_id_o          = flush_id;
	assign id_in_ready_o       = ~stall_i & ~halt_if & ~retain_id;
	assign instr_valid_clear_o = ~(stall_i | retain_id) | flush_id;

	// exception redirect only from FLUSH directly after DECODE
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(pc_set_o && pc_sel_o == ctrl_pkg::PC_EXC && exc_pc_sel_o == ctrl_pkg::EXC_PC_EXC)
		|-> (state_q == ctrl_pkg::FLUSH && $past(state_q) == ctrl_pkg::DECODE))
		else $error("exception redirect outside FLUSH");

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		!$isunknown(state_q) && state_q inside {ctrl_pkg::RESET, ctrl_pkg::BOOT_SET,
		ctrl_pkg::FIRST_FETCH, ctrl_pkg::DECODE, ctrl_pkg::FLUSH, ctrl_pkg::IRQ_TAKEN,
		ctrl_pkg::SLEEP, ctrl_pkg::WAIT_SLEEP})
		else $error("illegal controller state");

endmodule

`default_nettype wire

// File: design/ctrl_irq_arb.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_irq_arb #(
	parameter int unsigned NumFastIrqs = 15
) (
	input  logic [NumFastIrqs-1:0] irq_fast_i,
	input  logic                   irq_external_i,
	input  logic                   irq_software_i,
	input  logic                   irq_timer_i,
	input  logic                   irq_nm_i,
	input  logic                   mie_i,
	input  ctrl_pkg::priv_lvl_e    priv_i,
	input  logic                   nmi_mode_i,
	output logic                   irq_pending_o,
	output logic                   handle_irq_o,
	output logic                   nmi_o,
	output ctrl_pkg::exc_cause_t   irq_cause_o
);

	logic       irq_maskable;
	logic       irq_enabled;
	logic [3:0] fast_id;

	assign irq_maskable = (|irq_fast_i) | irq_external_i | irq_software_i | irq_timer_i;

	// user mode always takes interrupts
	assign irq_enabled = mie_i | (priv_i == ctrl_pkg::PRIV_U);

	// any raised line wakes the core, enabled or not
	assign irq_pending_o = irq_maskable | irq_nm_i;

	// an NMI is not nested
	assign nmi_o = irq_nm_i & ~nmi_mode_i;

	// lowest index fast line
	always_comb begin
		fast_id = '0;
		for (int i = NumFastIrqs - 1; i >= 0; i--) begin
			if (irq_fast_i[i]) begin
				fast_id = 4'(i);
			end
		end
	end

	always_comb begin
		handle_irq_o = ~nmi_mode_i & (irq_nm_i | (irq_maskable & irq_enabled));
		irq_cause_o  = '0;
		if (irq_nm_i) begin
			irq_cause_o = ctrl_pkg::CauseIrqNm;
		end else if (|irq_fast_i) begin
			// fast lines map to 48 + n
			irq_cause_o = {2'b01, 1'b1, fast_id};
		end else if (irq_external_i) begin
			irq_cause_o = ctrl_pkg::CauseIrqExternal;
		end else if (irq_software_i) begin
			irq_cause_o = ctrl_pkg::CauseIrqSoftware;
		end else if (irq_timer_i) begin
			irq_cause_o = ctrl_pkg::CauseIrqTimer;
		end
		// take decision and cause encoding must agree
		assert (!handle_irq_o || irq_cause_o[5])
			else $error("interrupt taken without an interrupt cause");
	end

endmodule

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// widths with a meaning
	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;

	// bit 5 flags an interrupt, low five bits hold the code
	typedef logic [6:0] exc_cause_t;

	typedef enum logic [1:0] {
		PRIV_U = 2'b00,
		PRIV_M = 2'b11
	} priv_lvl_e;

	typedef enum logic [2:0] {
		PC_BOOT = 3'd0,
		PC_JUMP = 3'd1,
		PC_EXC  = 3'd2,
		PC_MRET = 3'd3
	} pc_sel_e;

	typedef enum logic [1:0] {
		EXC_PC_EXC = 2'd0,
		EXC_PC_IRQ = 2'd1
	} exc_pc_sel_e;

	typedef enum logic [3:0] {
		RESET       = 4'd0,
		BOOT_SET    = 4'd1,
		FIRST_FETCH = 4'd2,
		DECODE      = 4'd3,
		FLUSH       = 4'd4,
		IRQ_TAKEN   = 4'd5,
		SLEEP       = 4'd6,
		WAIT_SLEEP  = 4'd7
	} ctrl_state_e;

	// decoder flags for the instruction in ID
	typedef struct packed {
		logic illegal;
		logic ecall;
		logic mret;
		logic wfi;
		logic ebrk;
		logic csr_pipe_flush;
		logic fetch_err;
		logic fetch_err_plus2;
	} id_flags_t;

	// winning synchronous exception
	typedef struct packed {
		logic       valid;
		logic       is_lsu;
		exc_cause_t cause;
		word_t      mtval;
	} exc_req_t;

	// commands towards the CSR file
	typedef struct packed {
		logic  save_if;
		logic  save_id;
		logic  save_cause;
		logic  restore_mret;
		word_t mtval;
	} csr_ctrl_t;

	localparam exc_cause_t CauseInstrFault  = 7'd1;
	localparam exc_cause_t CauseIllegal     = 7'd2;
	localparam exc_cause_t CauseBreakpoint  = 7'd3;
	localparam exc_cause_t CauseLoadFault   = 7'd5;
	localparam exc_cause_t CauseStoreFault  = 7'd7;
	localparam exc_cause_t CauseEcallU      = 7'd8;
	localparam exc_cause_t CauseEcallM      = 7'd11;
	localparam exc_cause_t CauseIrqSoftware = 7'd35;
	localparam exc_cause_t CauseIrqTimer    = 7'd39;
	localparam exc_cause_t CauseIrqExternal = 7'd43;
	localparam exc_cause_t CauseIrqNm       = 7'd63;

	localparam int unsigned MaxFastIrqs = 15;

endpackage

`default_nettype wire

// File: design/ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_top #(
	parameter int unsigned NumFastIrqs = ctrl_pkg::MaxFastIrqs
) (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	// decode stage
	input  logic                   instr_valid_i,
	input  ctrl_pkg::id_flags_t    flags_i,
	input  ctrl_pkg::word_t        instr_i,
	input  ctrl_pkg::half_t        instr_c_i,
	input  logic                   is_compressed_i,
	input  ctrl_pkg::word_t        pc_id_i,
	input  ctrl_pkg::priv_lvl_e    priv_i,
	input  logic                   branch_set_i,
	input  logic                   jump_set_i,
	input  logic                   stall_i,
	input  logic                   ready_wb_i,
	input  logic                   instr_exec_i,
	// load store unit
	input  logic                   load_err_i,
	input  logic                   store_err_i,
	input  ctrl_pkg::word_t        lsu_addr_i,
	// interrupt lines
	input  logic [NumFastIrqs-1:0] irq_fast_i,
	input  logic                   irq_external_i,
	input  logic                   irq_software_i,
	input  logic                   irq_timer_i,
	input  logic                   irq_nm_i,
	input  logic                   mie_i,
	// control outputs
	output logic                   special_pc_o,
	output logic                   ctrl_busy_o,
	output logic                   instr_req_o,
	output logic                   pc_set_o,
	output ctrl_pkg::pc_sel_e      pc_sel_o,
	output ctrl_pkg::exc_pc_sel_e  exc_pc_sel_o,
	output ctrl_pkg::exc_cause_t   exc_cause_o,
	output ctrl_pkg::csr_ctrl_t    csr_o,
	output logic                   nmi_mode_o,
	output logic                   id_in_ready_o,
	output logic                   instr_valid_clear_o,
	output logic                   flush_id_o
);

	ctrl_pkg::exc_req_t    exc_req;
	ctrl_pkg::ctrl_state_e state;
	ctrl_pkg::exc_cause_t  irq_cause;
	logic                  special;
	logic                  irq_pending;
	logic                  handle_irq;
	logic                  nmi;

	if (NumFastIrqs < 1 || NumFastIrqs > ctrl_pkg::MaxFastIrqs) begin : g_bad_fast_irqs
		$error("NumFastIrqs out of range");
	end

	ctrl_exc_prio i_exc_prio (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.instr_valid_i   (instr_valid_i),
		.flags_i         (flags_i),
		.instr_i         (instr_i),
		.instr_c_i       (instr_c_i),
		.is_compressed_i (is_compressed_i),
		.pc_id_i         (pc_id_i),
		.priv_i          (priv_i),
		.load_err_i      (load_err_i),
		.store_err_i     (store_err_i),
		.lsu_addr_i      (lsu_addr_i),
		.state_i         (state),
		.exc_o           (exc_req),
		.special_o       (special),
		.special_pc_o    (special_pc_o)
	);

	ctrl_irq_arb #(
		.NumFastIrqs (NumFastIrqs)
	) i_irq_arb (
		.irq_fast_i     (irq_fast_i),
		.irq_external_i (irq_external_i),
		.irq_software_i (irq_software_i),
		.irq_timer_i    (irq_timer_i),
		.irq_nm_i       (irq_nm_i),
		.mie_i          (mie_i),
		.priv_i         (priv_i),
		.nmi_mode_i     (nmi_mode_o),
		.irq_pending_o  (irq_pending),
		.handle_irq_o   (handle_irq),
		.nmi_o          (nmi),
		.irq_cause_o    (irq_cause)
	);

	ctrl_fsm i_fsm (
		.clk_i               (clk_i),
		.rst_ni              (rst_ni),
		.instr_valid_i       (instr_valid_i),
		.flags_i             (flags_i),
		.exc_i               (exc_req),
		.special_i           (special),
		.handle_irq_i        (handle_irq),
		.nmi_i               (nmi),
		.irq_cause_i         (irq_cause),
		.irq_pending_i       (irq_pending),
		.branch_set_i        (branch_set_i),
		.jump_set_i          (jump_set_i),
		.stall_i             (stall_i),
		.ready_wb_i          (ready_wb_i),
		.instr_exec_i        (instr_exec_i),
		.state_o             (state),
		.ctrl_busy_o         (ctrl_busy_o),
		.instr_req_o         (instr_req_o),
		.pc_set_o            (pc_set_o),
		.pc_sel_o            (pc_sel_o),
		.exc_pc_sel_o        (exc_pc_sel_o),
		.exc_cause_o         (exc_cause_o),
		.csr_o               (csr_o),
		.nmi_mode_o          (nmi_mode_o),
		.id_in_ready_o       (id_in_ready_o),
		.instr_valid_clear_o (instr_valid_clear_o),
		.flush_id_o          (flush_id_o)
	);

endmodule

`default_nettype wire

// File: verilog.f
design/ctrl_pkg.sv
design/ctrl_exc_prio.sv
design/ctrl_irq_arb.sv
design/ctrl_fsm.sv
design/ctrl_top.sv
bench/tb_ctrl.sv
